// File: flist.f
rtl/prbs_pkg.sv
rtl/lfsr_step.sv
rtl/prbs_gen.sv
rtl/prbs_check.sv
rtl/bert_ctrl.sv
rtl/prbs_bert_top.sv
dv/prbs_bert_tb.sv

// File: Makefile
# Verilator build and run for the prbs bert testbench
# override any variable on the command line, e.g. make run OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= prbs_bert_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= Simulation PASSED

SIM = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# status comes from the search for the pass line
run: compile
	@out="$$(./$(SIM))"; \
	printf '%s\n' "$$out"; \
	printf '%s\n' "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/prbs_bert_tb.sv
// bert testbench; reference prbs31 is bit-serial from all ones, runs are sequential, limit bounds the run
`default_nettype none
`timescale 1ns/1ps

module prbs_bert_tb;

    import prbs_pkg::*;

    localparam int N_DIR = 8;
    localparam int N_RND = 20;

    logic     clk;
    logic     rst;
    logic     req;
    run_req_t req_data;
    logic     ack;
    run_res_t res_data;

    // expected results in request order
    run_res_t exp_q[$];
    run_res_t exp_res;
    run_req_t dir_req [N_DIR];
    run_req_t rnd_req [N_RND];

    int   err_cnt;
    int   cmp_err_cnt;
    int   runs_checked;
    int   cycle_cnt;
    int   cycle_limit;
    int   seed;
    logic ack_seen;

    prbs_bert_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .req_data (req_data),
        .ack      (ack),
        .res_data (res_data)
    );

    // 20 ns period
    always #10 clk = ~clk;

    function automatic int count_ones(input logic [DATA_W-1:0] w);
        int n;
        n = 0;
        for (int i = 0; i < DATA_W; i++) begin
            if (w[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic run_req_t make_req(input int count, input int index,
                                          input logic [DATA_W-1:0] mask);
        run_req_t rq;
        rq.word_count = CNT_W'(count);
        rq.inj_index  = CNT_W'(index);
        rq.inj_mask   = mask;
        return rq;
    endfunction

    // expected result of one run
    // prbs31 x^31 + x^28 + 1, one bit per step, first bit into word msb
    function automatic run_res_t ref_run(input run_req_t rq);
        logic [30:0]       s;
        logic              fb;
        logic [DATA_W-1:0] word;
        logic [DATA_W-1:0] rx;
        run_res_t          res;
        int                n;
        res = '0;
        s   = '1;
        for (int w = 0; w < int'(rq.word_count); w++) begin
            word = '0;
            for (int b = DATA_W - 1; b >= 0; b--) begin
                // taps at stages 31 and 28
                fb      = s[30] ^ s[27];
                word[b] = fb;
                s       = {s[29:0], fb};
            end
            // inverted sequence on the link
            word = ~word;
            rx   = word;
            if (w == int'(rq.inj_index)) begin
                rx = word ^ rq.inj_mask;
            end
            n = count_ones(rx ^ word);
            res.bit_errors = res.bit_errors + ERR_W'(n);
            if (n != 0) begin
                res.err_words = res.err_words + CNT_W'(1);
                if (!res.any_err) begin
                    res.first_err_index = CNT_W'(w);
                    res.any_err         = 1'b1;
                end
            end
            // generator word, before injection
            res.last_word = word;
        end
        return res;
    endfunction

    // field by field compare, returns the number of mismatches
    function automatic int count_mismatches(input run_res_t e, input run_res_t g);
        int n;
        n = 0;
        assert (g.bit_errors == e.bit_errors) else begin
            $display("FAILED at %0t: bit_errors is %0d, expected %0d",
                     $time, g.bit_errors, e.bit_errors);
            n++;
        end
        assert (g.err_words == e.err_words) else begin
            $display("FAILED at %0t: err_words is %0d, expected %0d",
                     $time, g.err_words, e.err_words);
            n++;
        end
        assert (g.first_err_index == e.first_err_index) else begin
            $display("FAILED at %0t: first_err_index is %0d, expected %0d",
                     $time, g.first_err_index, e.first_err_index);
            n++;
        end
        assert (g.any_err == e.any_err) else begin
            $display("FAILED at %0t: any_err is %0d, expected %0d",
                     $time, g.any_err, e.any_err);
            n++;
        end
        assert (g.last_word == e.last_word) else begin
            $display("FAILED at %0t: last_word is %08h, expected %08h",
                     $time, g.last_word, e.last_word);
            n++;
        end
        return n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // one four-phase transaction
    // called and returns 1 ns after a rising edge
    task automatic do_run(input run_req_t rq, input int hold, output run_res_t got);
        int waited;
        exp_q.push_back(ref_run(rq));
        req_data = rq;
        req      = 1'b1;
        @(posedge clk);
        #1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        got = res_data;
        // req held longer, ack and result must not move
        for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            #1;
            assert (ack) else begin
                $display("ack dropped at %0t while req was still high", $time);
                err_cnt++;
            end
            assert (res_data == got) else begin
                $display("FAILED at %0t: res_data changed while ack was held", $time);
                err_cnt++;
            end
        end
        req    = 1'b0;
        waited = 0;
        while (ack && waited < 3) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (!ack && waited == 1) else begin
            $display("ack did not fall one cycle after req dropped (%0t)", $time);
            err_cnt++;
        end
    endtask

    // compare at each ack rise, sampled mid-cycle
    always @(negedge clk) begin
        if (ack && !ack_seen) begin
            if (exp_q.size() == 0) begin
                $display("ack rose at %0t with no run outstanding", $time);
                cmp_err_cnt++;
            end else begin
                exp_res = exp_q.pop_front();
                cmp_err_cnt += count_mismatches(exp_res, res_data);
                runs_checked++;
            end
        end
        ack_seen = ack;
    end

    // run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: %0d cycles passed before the tests finished", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        run_res_t    got;
        run_res_t    first_got;
        logic [31:0] r;

        clk          = 1'b0;
        rst          = 1'b1;
        req          = 1'b0;
        req_data     = '0;
        err_cnt      = 0;
        cmp_err_cnt  = 0;
        runs_checked = 0;
        cycle_cnt    = 0;
        ack_seen     = 1'b0;
        seed         = 32'hf3ee_a205;

        // directed runs
        dir_req[0] = make_req(64, 0, 32'h0000_0000);
        dir_req[1] = make_req(64, 10, 32'h0000_0100);
        dir_req[2] = make_req(64, 37, 32'hf00d_0003);
        // index at count, then far beyond
        dir_req[3] = make_req(32, 32, 32'hffff_ffff);
        dir_req[4] = make_req(32, 500, 32'h0000_0001);
        dir_req[5] = make_req(0, 0, 32'hffff_ffff);
        dir_req[6] = make_req(40, 5, 32'h8000_0001);
        dir_req[7] = dir_req[6];

        // random runs, index may land past the end
        for (int k = 0; k < N_RND; k++) begin
            r = $random(seed);
            rnd_req[k].word_count = CNT_W'(32'd1 + (r % 32'd200));
            r = $random(seed);
            rnd_req[k].inj_index = CNT_W'(r % (32'(rnd_req[k].word_count) + 32'd16));
            r = $random(seed);
            rnd_req[k].inj_mask = $random(seed);
            // about one in four clean
            if (r[1:0] == 2'd0) begin
                rnd_req[k].inj_mask = '0;
            end
        end

        // limit from run lengths
        cycle_limit = 100;
        for (int k = 0; k < N_DIR; k++) begin
            cycle_limit += int'(dir_req[k].word_count) + 10;
        end
        for (int k = 0; k < N_RND; k++) begin
            cycle_limit += int'(rnd_req[k].word_count) + 10;
        end

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (!ack && res_data == '0) else begin
            $display("ack or res_data not cleared by reset at %0t", $time);
            err_cnt++;
        end

        // clean run
        do_run(dir_req[0], 0, got);
        check_value("clean bit_errors", 32'(got.bit_errors), 32'd0);
        check_value("clean err_words", 32'(got.err_words), 32'd0);
        check_value("clean any_err", 32'(got.any_err), 32'd0);

        // single bit at word 10
        do_run(dir_req[1], 0, got);
        check_value("single bit_errors", 32'(got.bit_errors), 32'd1);
        check_value("single err_words", 32'(got.err_words), 32'd1);
        check_value("single first_err_index", 32'(got.first_err_index), 32'd10);
        check_value("single any_err", 32'(got.any_err), 32'd1);

        // multi-bit mask counts every flipped bit
        do_run(dir_req[2], 0, got);
        check_value("multi bit_errors", 32'(got.bit_errors),
                    32'(count_ones(dir_req[2].inj_mask)));
        check_value("multi err_words", 32'(got.err_words), 32'd1);
        check_value("multi first_err_index", 32'(got.first_err_index), 32'd37);

        // out of range index, nothing injected
        do_run(dir_req[3], 0, got);
        check_value("index at count bit_errors", 32'(got.bit_errors), 32'd0);
        check_value("index at count any_err", 32'(got.any_err), 32'd0);
        do_run(dir_req[4], 0, got);
        check_value("index beyond bit_errors", 32'(got.bit_errors), 32'd0);
        check_value("index beyond any_err", 32'(got.any_err), 32'd0);

        // empty run
        do_run(dir_req[5], 0, got);
        assert (got == '0) else begin
            $display("FAILED at %0t: zero-length result is not all zero", $time);
            err_cnt++;
        end

        // held req, then the same run again
        do_run(dir_req[6], 4, first_got);
        do_run(dir_req[7], 0, got);
        assert (got == first_got) else begin
            $display("FAILED at %0t: back-to-back runs gave different results", $time);
            err_cnt++;
        end

        for (int k = 0; k < N_RND; k++) begin
            do_run(rnd_req[k], 0, got);
        end

        @(posedge clk);
        #1;
        assert (exp_q.size() == 0) else begin
            $display("%0d runs ended without a checked result", exp_q.size());
            err_cnt++;
        end

        $display("errors: %0d, runs checked: %0d", err_cnt + cmp_err_cnt, runs_checked);
        if (err_cnt + cmp_err_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/prbs_bert_top.sv
// bert top; link is an internal zero-latency loopback, no serdes and no free-running monitor
`default_nettype none
`timescale 1ns/1ps

module prbs_bert_top (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  req,
    input  wire prbs_pkg::run_req_t    req_data,
    output logic                       ack,
    output prbs_pkg::run_res_t         res_data
);

    import prbs_pkg::*;

    logic              restart;
    logic              advance;
    logic [DATA_W-1:0] gen_word;
    logic [DATA_W-1:0] link_word;
    chk_stat_t         stat;

    // handshake, sequencing and injection
    bert_ctrl ctrl0 (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .ack       (ack),
        .res_data  (res_data),
        .restart   (restart),
        .advance   (advance),
        .gen_word  (gen_word),
        .link_word (link_word),
        .stat      (stat)
    );

    // transmit side
    prbs_gen gen0 (
        .clk      (clk),
        .rst      (rst),
        .restart  (restart),
        .advance  (advance),
        .data_out (gen_word)
    );

    // receive side, fed straight from the loopback
    prbs_check check0 (
        .clk     (clk),
        .rst     (rst),
        .restart (restart),
        .advance (advance),
        .data_in (link_word),
        .stat    (stat)
    );

endmodule

`default_nettype wire

// File: rtl/bert_ctrl.sv
// bert run controller; four-phase req/ack, one run at a time, req_data must hold while req is high
`default_nettype none
`timescale 1ns/1ps

module bert_ctrl (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          req,
    input  wire prbs_pkg::run_req_t            req_data,
    output logic                               ack,
    output prbs_pkg::run_res_t                 res_data,
    output logic                               restart,
    output logic                               advance,
    input  wire logic [prbs_pkg::DATA_W-1:0]   gen_word,
    output logic      [prbs_pkg::DATA_W-1:0]   link_word,
    input  wire prbs_pkg::chk_stat_t           stat
);

    import prbs_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_RESTART,
        ST_SEND,
        ST_SETTLE,
        ST_DONE
    } state_t;

    state_t            state;
    run_req_t          req_q;
    logic [CNT_W-1:0]  word_idx;
    logic [DATA_W-1:0] last_word;
    logic              inj_hit;
    logic              last_send;

    // both lfsrs see the same strobes
    assign restart = (state == ST_RESTART);
    assign advance = (state == ST_SEND);

    // corrupt exactly one word of the run
    assign inj_hit   = advance && (word_idx == req_q.inj_index);
    assign link_word = inj_hit ? (gen_word ^ req_q.inj_mask) : gen_word;

    assign last_send = (word_idx == req_q.word_count - CNT_W'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            ack      <= 1'b0;
            res_data <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // new run only after the previous ack fell
                    if (req && !ack) begin
                        state <= ST_RESTART;
                    end
                end
                ST_RESTART: begin
                    // empty run skips straight to settle
                    state <= (req_q.word_count == '0) ? ST_SETTLE : ST_SEND;
                end
                ST_SEND: begin
                    if (last_send) begin
                        state <= ST_SETTLE;
                    end
                end
                ST_SETTLE: begin
                    // checker stats now include the final word
                    res_data.bit_errors      <= stat.bit_errors;
                    res_data.err_words       <= stat.err_words;
                    res_data.first_err_index <= stat.first_err_index;
                    res_data.any_err         <= stat.any_err;
                    res_data.last_word       <= last_word;
                    ack                      <= 1'b1;
                    state                    <= ST_DONE;
                end
                ST_DONE: begin
                    // hold the result until the host lets go
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // request capture and word tracking
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req && !ack) begin
            req_q <= req_data;
        end
        if (state == ST_RESTART) begin
            word_idx  <= '0;
            last_word <= '0;
        end else if (advance) begin
            word_idx  <= word_idx + CNT_W'(1);
            last_word <= gen_word;
        end
    end

    // ack only ever answers a live request
    // req was high on the edge that raised ack
    ack_needs_req: assert property (
        @(posedge clk) disable iff (rst)
        $rose(ack) |-> $past(req)
    );

    // advance never runs past the requested word count
    advance_in_send: assert property (
        @(posedge clk) disable iff (rst)
        advance |-> word_idx < req_q.word_count
    );

endmodule

`default_nettype wire

// File: rtl/prbs_check.sv
// lock-step prbs31 checker; assumes zero link latency and counters that never wrap within a run
`default_nettype none
`timescale 1ns/1ps

module prbs_check (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          restart,
    input  wire logic                          advance,
    input  wire logic [prbs_pkg::DATA_W-1:0]   data_in,
    output prbs_pkg::chk_stat_t                stat
);

    import prbs_pkg::*;

    logic [LFSR_W-1:0] state_reg;
    logic [LFSR_W-1:0] state_next;
    logic [DATA_W-1:0] raw_word;
    logic [DATA_W-1:0] exp_word;
    logic [DATA_W-1:0] diff;
    logic [POP_W-1:0]  pop;
    logic [CNT_W-1:0]  word_idx;

    // same sequence as the generator
    lfsr_step #(
        .LFSR_W    (LFSR_W),
        .LFSR_POLY (LFSR_POLY),
        .DATA_W    (DATA_W)
    ) step0 (
        .state_in  (state_reg),
        .data_out  (raw_word),
        .state_out (state_next)
    );

    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state_reg <= LFSR_INIT;
        end else if (advance) begin
            state_reg <= state_next;
        end
    end

    // expected word, then flipped bits
    assign exp_word = PRBS_INVERT ? ~raw_word : raw_word;
    assign diff     = exp_word ^ data_in;
    assign pop      = POP_W'($countones(diff));

    // statistics, one update per advanced word
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            stat     <= '0;
            word_idx <= '0;
        end else if (advance) begin
            word_idx        <= word_idx + CNT_W'(1);
            stat.bit_errors <= stat.bit_errors + ERR_W'(pop);
            if (pop != '0) begin
                stat.err_words <= stat.err_words + CNT_W'(1);
                // first bad word only
                if (!stat.any_err) begin
                    stat.first_err_index <= word_idx;
                    stat.any_err         <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/prbs_gen.sv
// prbs31 word source; data_out is combinational from state, restart and advance must never coincide
`default_nettype none
`timescale 1ns/1ps

module prbs_gen (
    input  wire logic                          clk,
    input  wire logic                          rst,
    input  wire logic                          restart,
    input  wire logic                          advance,
    output logic      [prbs_pkg::DATA_W-1:0]   data_out
);

    import prbs_pkg::*;

    logic [LFSR_W-1:0] state_reg;
    logic [LFSR_W-1:0] state_next;
    logic [DATA_W-1:0] raw_word;

    // next word and next state from the current state
    lfsr_step #(
        .LFSR_W    (LFSR_W),
        .LFSR_POLY (LFSR_POLY),
        .DATA_W    (DATA_W)
    ) step0 (
        .state_in  (state_reg),
        .data_out  (raw_word),
        .state_out (state_next)
    );

    // restart wins so every run begins at LFSR_INIT
    always_ff @(posedge clk) begin
        if (rst || restart) begin
            state_reg <= LFSR_INIT;
        end else if (advance) begin
            state_reg <= state_next;
        end
    end

    // word on the link this cycle
    assign data_out = PRBS_INVERT ? ~raw_word : raw_word;

    // controller sequences restart strictly before the first advance
    restart_advance_excl: assert property (
        @(posedge clk) disable iff (rst)
        restart |-> !advance ##1 !restart
    );

endmodule

`default_nettype wire

// File: rtl/lfsr_step.sv
// fibonacci lfsr unrolled over DATA_W shifts, msb first, purely combinational; needs LFSR_W >= 2
`default_nettype none
`timescale 1ns/1ps

module lfsr_step #(
    parameter int LFSR_W = prbs_pkg::LFSR_W,
    parameter logic [LFSR_W-1:0] LFSR_POLY = prbs_pkg::LFSR_POLY,
    parameter int DATA_W = prbs_pkg::DATA_W
) (
    input  wire logic [LFSR_W-1:0] state_in,
    output logic      [DATA_W-1:0] data_out,
    output logic      [LFSR_W-1:0] state_out
);

    // one shift per output bit
    // feedback is the top bit xor the tapped lower bits
    // poly bit 0 is the constant term and drops out
    always_comb begin : unroll
        logic [LFSR_W-1:0] st;
        logic fb;

        st = state_in;
        fb = 1'b0;
        data_out = '0;

        // first bit out lands in the word msb
        for (int i = DATA_W - 1; i >= 0; i--) begin
            fb = st[LFSR_W-1] ^ (^(st[LFSR_W-2:0] & LFSR_POLY[LFSR_W-1:1]));
            data_out[i] = fb;
            // shift up, feedback enters at bit 0
            st = {st[LFSR_W-2:0], fb};
        end

        // state after all DATA_W shifts
        state_out = st;
    end

endmodule

`default_nettype wire

// File: rtl/prbs_pkg.sv
// shared prbs31 bert constants and records; LFSR_W must be at least 2, widths fixed at build time
`default_nettype none

package prbs_pkg;

    // lfsr register width
    localparam int LFSR_W = 31;

    // prbs31 taps, x^31 + x^28 + 1
    // top term implied by LFSR_W, bit 0 is the +1 term
    localparam logic [LFSR_W-1:0] LFSR_POLY = 31'h1000_0001;

    // every run starts here
    localparam logic [LFSR_W-1:0] LFSR_INIT = '1;

    // link word width, bits per cycle
    localparam int DATA_W = 32;

    // inverted prbs31 as in itu o.151
    localparam logic PRBS_INVERT = 1'b1;

    // word counts and word indices
    localparam int CNT_W = 16;

    // bit error accumulator
    // 2^24 covers a full 65535-word run with every bit wrong
    localparam int ERR_W = 24;

    // popcount of one word, 0 to DATA_W
    localparam int POP_W = $clog2(DATA_W + 1);

    // host request, held stable while req is high
    typedef struct packed {
        // words to send, 0 is legal
        logic [CNT_W-1:0] word_count;
        // word that gets corrupted
        logic [CNT_W-1:0] inj_index;
        // xor mask, zero means clean run
        logic [DATA_W-1:0] inj_mask;
    } run_req_t;

    // run result returned with ack
    typedef struct packed {
        logic [ERR_W-1:0] bit_errors;
        logic [CNT_W-1:0] err_words;
        // only meaningful with any_err set
        logic [CNT_W-1:0] first_err_index;
        logic any_err;
        // generator word before injection
        logic [DATA_W-1:0] last_word;
    } run_res_t;

    // checker statistics toward the controller
    typedef struct packed {
        logic [ERR_W-1:0] bit_errors;
        logic [CNT_W-1:0] err_words;
        logic [CNT_W-1:0] first_err_index;
        logic any_err;
    } chk_stat_t;

endpackage

`default_nettype wire
